//--- include/invsqrt_consts.svh
`ifndef INVSQRT_CONSTS_SVH
`define INVSQRT_CONSTS_SVH

// ====================
// Pipeline timing
// ====================
// Cycles from in_valid to out_valid
`define INVSQRT_LATENCY 4

// ====================
// Seed table geometry
// ====================
// Exponent parity bit plus leading mantissa bits
`define INVSQRT_ROM_ADDR_BITS 10
`define INVSQRT_SEED_BITS 16
// Seed holds 1.0 as 0x8000
`define INVSQRT_SEED_FRAC_BITS 15

// ====================
// Fixed point and encodings
// ====================
`define INVSQRT_FIX_BITS 64
`define INVSQRT_FRAC_BITS 62
`define INVSQRT_HALF_EXP_BITS 12
`define FP64_EXP_BIAS 1023
`define FP64_EXP_MAX 11'h7ff
`define FP64_QNAN 64'h7ff8_0000_0000_0001
`define FP64_POS_INF 64'h7ff0_0000_0000_0000
`define FP64_POS_ZERO 64'h0000_0000_0000_0000

`endif

//--- hw/fp64_pkg.sv
package fp64_pkg;

    // ====================
    // Binary64 layout
    // ====================
    // Field widths
    localparam int exp_bits  = 11;
    localparam int mant_bits = 52;
    // Sign, exponent, fraction
    localparam int word_bits = 1 + exp_bits + mant_bits;

    // Sign bit on its own
    typedef logic fp_sign_t;

    // Biased exponent field
    typedef logic [exp_bits-1:0] fp_exp_t;

    // Stored fraction, hidden bit not included
    typedef logic [mant_bits-1:0] fp_mant_t;

    // Whole word as seen on the ports
    typedef logic [word_bits-1:0] fp64_t;

endpackage

//--- hw/invsqrt_pkg.sv
`include "invsqrt_consts.svh"

package invsqrt_pkg;

    // ====================
    // Operand classes
    // ====================
    // Denormals fold into zero or negative by sign
    typedef enum logic [2:0] {
        class_nan     = 3'd0,
        class_neg     = 3'd1,
        class_pos_inf = 3'd2,
        class_zero    = 3'd3,
        class_pos_fin = 3'd4
    } fp_class_t;

    // ====================
    // Iteration types
    // ====================
    // Unsigned, two integer bits above the binary point
    typedef logic [`INVSQRT_FIX_BITS-1:0] fix_t;

    // Signed unbiased exponent, wide enough for the bias offset
    typedef logic signed [`INVSQRT_HALF_EXP_BITS-1:0] half_exp_t;

endpackage

//--- hw/invsqrt_ifs.sv
`timescale 1ns/1ps

// Special-case result, classifier to selector
interface special_if;

    // One-cycle strobe per operand
    logic                    valid;
    // Class decoded from the operand
    invsqrt_pkg::fp_class_t  op_class;
    // Encoding picked for the class
    fp64_pkg::fp64_t         result;
    // Set for every class except finite positive
    logic                    is_special;

    modport producer (
        output valid,
        output op_class,
        output result,
        output is_special
    );

    modport consumer (
        input valid,
        input op_class,
        input result,
        input is_special
    );

endinterface

// Approximate result, Newton path to selector
interface approx_if;

    logic                valid;
    // Always positive
    fp64_pkg::fp_sign_t  sign;
    fp64_pkg::fp_exp_t   exp;
    fp64_pkg::fp_mant_t  mant;

    modport producer (output valid, output sign, output exp, output mant);

    modport consumer (input valid, input sign, input exp, input mant);

endinterface

//--- hw/fp_classify.sv
`timescale 1ns/1ps
`include "invsqrt_consts.svh"

module fp_classify (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  fp64_pkg::fp64_t  fp_in,
    special_if.producer      special
);

    // Matches the Newton path depth
    localparam int stages = `INVSQRT_LATENCY - 1;

    fp64_pkg::fp_sign_t      in_sign;
    fp64_pkg::fp_exp_t       in_exp;
    fp64_pkg::fp_mant_t      in_mant;
    invsqrt_pkg::fp_class_t  in_class;
    fp64_pkg::fp64_t         in_result;

    logic [stages-1:0]       valid_q;
    invsqrt_pkg::fp_class_t  class_q [stages];
    fp64_pkg::fp64_t         result_q [stages];

    // Field split
    assign in_sign = fp_in[fp64_pkg::word_bits-1];
    assign in_exp  = fp_in[fp64_pkg::mant_bits +: fp64_pkg::exp_bits];
    assign in_mant = fp_in[fp64_pkg::mant_bits-1:0];

    // ====================
    // Class decode
    // ====================
    always_comb begin
        if (in_exp == `FP64_EXP_MAX && in_mant != '0) begin
            in_class = invsqrt_pkg::class_nan;
        // Any negative except a true zero, denormals included
        end else if (in_sign && (in_exp != '0 || in_mant != '0)) begin
            in_class = invsqrt_pkg::class_neg;
        end else if (in_exp == `FP64_EXP_MAX) begin
            in_class = invsqrt_pkg::class_pos_inf;
        // Both zeros and flushed positive denormals
        end else if (in_exp == '0) begin
            in_class = invsqrt_pkg::class_zero;
        end else begin
            in_class = invsqrt_pkg::class_pos_fin;
        end
    end

    // Special encoding per class
    always_comb begin
        case (in_class)
            invsqrt_pkg::class_nan:     in_result = `FP64_QNAN;
            invsqrt_pkg::class_neg:     in_result = `FP64_QNAN;
            invsqrt_pkg::class_pos_inf: in_result = `FP64_POS_ZERO;
            invsqrt_pkg::class_zero:    in_result = `FP64_POS_INF;
            // Unused, selector takes the approximation
            default:                    in_result = `FP64_POS_ZERO;
        endcase
    end

    // ====================
    // Delay line
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[stages-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        class_q[0]  <= in_class;
        result_q[0] <= in_result;
        for (int i = 1; i < stages; i++) begin
            class_q[i]  <= class_q[i-1];
            result_q[i] <= result_q[i-1];
        end
    end

    assign special.valid      = valid_q[stages-1];
    assign special.op_class   = class_q[stages-1];
    assign special.result     = result_q[stages-1];
    assign special.is_special = (class_q[stages-1] != invsqrt_pkg::class_pos_fin);

endmodule

//--- hw/invsqrt_seed_rom.sv
`timescale 1ns/1ps
`include "invsqrt_consts.svh"

module invsqrt_seed_rom (
    input  logic                               clk,
    input  logic [`INVSQRT_ROM_ADDR_BITS-1:0]  addr,
    output logic [`INVSQRT_SEED_BITS-1:0]      seed
);

    localparam int depth     = 1 << `INVSQRT_ROM_ADDR_BITS;
    // Mantissa bits in the index
    localparam int idx_bits  = `INVSQRT_ROM_ADDR_BITS - 1;
    // Numerator exponent, seed^2 scale times segment scale
    localparam int num_shift = 2 * `INVSQRT_SEED_FRAC_BITS + idx_bits;

    logic [`INVSQRT_SEED_BITS-1:0] seed_table [depth];

    // Bitwise integer square root, floor
    function automatic logic [63:0] isqrt(input logic [63:0] v);
        logic [63:0] root;
        logic [63:0] trial;
        root = '0;
        for (int b = 31; b >= 0; b--) begin
            trial = root | (64'd1 << b);
            if (trial * trial <= v) begin
                root = trial;
            end
        end
        return root;
    endfunction

    // Seed for the low end of one segment of m in [1,4)
    function automatic logic [`INVSQRT_SEED_BITS-1:0] seed_value(input int unsigned entry);
        logic [63:0] seg_lo;
        logic [63:0] quot;
        logic [63:0] root;
        // Segment start scaled by 2^idx_bits
        seg_lo = 64'((1 << idx_bits) + (entry % (1 << idx_bits)));
        // Upper half of the table covers m in [2,4)
        if (entry >= (1 << idx_bits)) begin
            seg_lo = seg_lo << 1;
        end
        quot = (64'd1 << num_shift) / seg_lo;
        root = isqrt(quot);
        return root[`INVSQRT_SEED_BITS-1:0];
    endfunction

    // Table contents fixed at start of simulation
    initial begin
        for (int i = 0; i < depth; i++) begin
            seed_table[i] = seed_value(i);
        end
    end

    // One cycle read
    always_ff @(posedge clk) begin
        seed <= seed_table[addr];
    end

endmodule

//--- hw/invsqrt_newton.sv
`timescale 1ns/1ps
`include "invsqrt_consts.svh"

module invsqrt_newton (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  fp64_pkg::fp64_t  fp_in,
    approx_if.producer       approx
);

    localparam int mant_bits  = fp64_pkg::mant_bits;
    // Seed format to fix_t alignment
    localparam int seed_shift = `INVSQRT_FRAC_BITS - `INVSQRT_SEED_FRAC_BITS;
    // 1.5 in fix_t
    localparam invsqrt_pkg::fix_t three_halves =
        invsqrt_pkg::fix_t'(3) << (`INVSQRT_FRAC_BITS - 1);

    // One step of y * (1.5 - (m/2) * y^2), truncating
    function automatic invsqrt_pkg::fix_t nr_step(
        input invsqrt_pkg::fix_t m,
        input invsqrt_pkg::fix_t y
    );
        logic [2*`INVSQRT_FIX_BITS-1:0] prod;
        invsqrt_pkg::fix_t y_sq;
        invsqrt_pkg::fix_t half_m_y_sq;
        invsqrt_pkg::fix_t corr;
        prod        = y * y;
        y_sq        = prod[`INVSQRT_FRAC_BITS +: `INVSQRT_FIX_BITS];
        // Low bits of m are zero so halving is exact
        prod        = (m >> 1) * y_sq;
        half_m_y_sq = prod[`INVSQRT_FRAC_BITS +: `INVSQRT_FIX_BITS];
        corr        = three_halves - half_m_y_sq;
        prod        = y * corr;
        return prod[`INVSQRT_FRAC_BITS +: `INVSQRT_FIX_BITS];
    endfunction

    fp64_pkg::fp_exp_t                  in_exp;
    fp64_pkg::fp_mant_t                 in_mant;
    logic                               exp_odd;
    invsqrt_pkg::half_exp_t             unb_exp;
    invsqrt_pkg::half_exp_t             even_exp;
    invsqrt_pkg::fix_t                  m_base;
    logic [`INVSQRT_ROM_ADDR_BITS-1:0]  rom_addr;
    logic [`INVSQRT_SEED_BITS-1:0]      seed;
    invsqrt_pkg::fix_t                  y0;

    logic                    s1_valid;
    invsqrt_pkg::fix_t       s1_m;
    invsqrt_pkg::half_exp_t  s1_res_exp;
    logic                    s2_valid;
    invsqrt_pkg::fix_t       s2_m;
    invsqrt_pkg::fix_t       s2_y;
    invsqrt_pkg::half_exp_t  s2_res_exp;

    invsqrt_pkg::fix_t       y2;
    invsqrt_pkg::half_exp_t  exp_base;
    fp64_pkg::fp_exp_t       pack_exp;
    fp64_pkg::fp_mant_t      pack_mant;

    // ====================
    // Stage one
    // ====================
    assign in_exp  = fp_in[mant_bits +: fp64_pkg::exp_bits];
    assign in_mant = fp_in[mant_bits-1:0];
    // Bias is odd, so an even biased exponent is odd unbiased
    assign exp_odd = ~in_exp[0];
    assign unb_exp = $signed({1'b0, in_exp}) - invsqrt_pkg::half_exp_t'(`FP64_EXP_BIAS);
    // Round down to even, also right for negatives
    assign even_exp = unb_exp & ~invsqrt_pkg::half_exp_t'(1);
    // 1.f in fix_t
    assign m_base = {2'b01, in_mant, {(`INVSQRT_FRAC_BITS - mant_bits){1'b0}}};
    assign rom_addr = {exp_odd, in_mant[mant_bits-1 -: `INVSQRT_ROM_ADDR_BITS-1]};

    invsqrt_seed_rom invsqrt_seed_rom_i (
        .clk  (clk),
        .addr (rom_addr),
        .seed (seed)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // Odd exponent moves one factor of two into m
    always_ff @(posedge clk) begin
        s1_m       <= exp_odd ? (m_base << 1) : m_base;
        s1_res_exp <= -(even_exp >>> 1);
    end

    // ====================
    // Stage two
    // ====================
    assign y0 = invsqrt_pkg::fix_t'(seed) << seed_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_y       <= nr_step(s1_m, y0);
        s2_m       <= s1_m;
        s2_res_exp <= s1_res_exp;
    end

    // ====================
    // Stage three
    // ====================
    assign y2       = nr_step(s2_m, s2_y);
    assign exp_base = s2_res_exp + invsqrt_pkg::half_exp_t'(`FP64_EXP_BIAS);

    // y2 lies in (0.5,1], truncation may dip just under 0.5
    always_comb begin
        if (y2[`INVSQRT_FRAC_BITS]) begin
            pack_exp  = fp64_pkg::fp_exp_t'(exp_base);
            pack_mant = y2[`INVSQRT_FRAC_BITS-1 -: mant_bits];
        end else if (y2[`INVSQRT_FRAC_BITS-1]) begin
            pack_exp  = fp64_pkg::fp_exp_t'(exp_base - 1);
            pack_mant = y2[`INVSQRT_FRAC_BITS-2 -: mant_bits];
        end else begin
            pack_exp  = fp64_pkg::fp_exp_t'(exp_base - 2);
            pack_mant = y2[`INVSQRT_FRAC_BITS-3 -: mant_bits];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            approx.valid <= 1'b0;
        end else begin
            approx.valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        approx.exp  <= pack_exp;
        approx.mant <= pack_mant;
    end

    // Result of 1/sqrt is never negative
    assign approx.sign = 1'b0;

endmodule

//--- hw/invsqrt_result_select.sv
`timescale 1ns/1ps

module invsqrt_result_select (
    input  logic             clk,
    input  logic             reset,
    special_if.consumer      special,
    approx_if.consumer       approx,
    output logic             out_valid,
    output fp64_pkg::fp64_t  fp_out
);

    // Packed approximation
    fp64_pkg::fp64_t approx_word;
    // Finite positive operand with a valid approximation
    logic            use_approx;

    // ====================
    // Merge
    // ====================
    assign approx_word = {approx.sign, approx.exp, approx.mant};

    // Both valids arrive in the same cycle
    assign use_approx = approx.valid & ~special.is_special;

    // Output strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= special.valid;
        end
    end

    // Result register
    // Holds its value between strobes
    always_ff @(posedge clk) begin
        if (special.valid) begin
            if (use_approx) begin
                fp_out <= approx_word;
            end else begin
                fp_out <= special.result;
            end
        end
    end

endmodule

//--- hw/fp64_invsqrt.sv
`timescale 1ns/1ps

module fp64_invsqrt (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  fp64_pkg::fp64_t  fp_in,
    output logic             out_valid,
    output fp64_pkg::fp64_t  fp_out
);

    // ====================
    // Internal buses
    // ====================
    // Classifier to selector
    special_if special_if_i ();
    // Newton path to selector
    approx_if  approx_if_i ();

    // ====================
    // Special cases
    // ====================
    // Decodes class and aligns it to the approximation
    fp_classify fp_classify_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .fp_in    (fp_in),
        .special  (special_if_i.producer)
    );

    // ====================
    // Approximation
    // ====================
    // Seed plus two iterations, three cycles
    invsqrt_newton invsqrt_newton_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .fp_in    (fp_in),
        .approx   (approx_if_i.producer)
    );

    // ====================
    // Output
    // ====================
    // Final register, one cycle
    invsqrt_result_select invsqrt_result_select_i (
        .clk       (clk),
        .reset     (reset),
        .special   (special_if_i.consumer),
        .approx    (approx_if_i.consumer),
        .out_valid (out_valid),
        .fp_out    (fp_out)
    );

endmodule

//--- sim/fp64_invsqrt_properties.sv
`timescale 1ns/1ps
`include "invsqrt_consts.svh"

module fp64_invsqrt_properties (
    input logic            clk,
    input logic            reset,
    input logic            in_valid,
    input fp64_pkg::fp64_t fp_in,
    input logic            out_valid,
    input fp64_pkg::fp64_t fp_out
);

    // Failed assertions, read by the testbench at the end
    int assert_fails = 0;
    // Edges since time zero, saturates at the latency
    int edges_seen = 0;

    always @(posedge clk) begin
        if (edges_seen < `INVSQRT_LATENCY) begin
            edges_seen <= edges_seen + 1;
        end
    end

    function automatic logic is_nan(input fp64_pkg::fp64_t x);
        return x[fp64_pkg::mant_bits +: fp64_pkg::exp_bits] == `FP64_EXP_MAX
            && x[fp64_pkg::mant_bits-1:0] != '0;
    endfunction

    // ====================
    // Valid timing
    // ====================
    latency_match: assert property (
        @(posedge clk) disable iff (reset)
        (edges_seen >= `INVSQRT_LATENCY) |-> (out_valid == $past(in_valid, `INVSQRT_LATENCY))
    ) else begin
        assert_fails++;
        $error("out_valid does not follow in_valid by the pipeline latency");
    end

    // ====================
    // Reset
    // ====================
    quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid) else begin
        assert_fails++;
        $error("out_valid high while reset is asserted");
    end

    quiet_after_reset: assert property (@(posedge clk) $fell(reset) |=> !out_valid) else begin
        assert_fails++;
        $error("out_valid high in the cycle after reset");
    end

    // ====================
    // NaN result
    // ====================
    nan_result: assert property (
        @(posedge clk) disable iff (reset)
        (in_valid && is_nan(fp_in)) |-> ##`INVSQRT_LATENCY (out_valid && fp_out == `FP64_QNAN)
    ) else begin
        assert_fails++;
        $error("NaN operand did not give the quiet NaN");
    end

endmodule

//--- sim/fp64_invsqrt_tb.sv
`timescale 1ns/1ps
`include "invsqrt_consts.svh"

module fp64_invsqrt_tb;

    localparam int period       = 20;
    localparam int lat_ns       = `INVSQRT_LATENCY * period;
    localparam int reset_cycles = 2;
    localparam int idle_cycles  = 10;
    localparam int n_special    = 12;
    localparam int n_pow4       = 41;
    localparam int n_random     = 200;
    localparam int n_burst      = 24;
    localparam int n_gapped     = 40;
    localparam int max_gap      = 3;
    // Cycle budget of all tests, drains included
    localparam int test_cycles  = reset_cycles + idle_cycles + n_special + n_pow4 + n_random
        + n_burst + n_gapped * (1 + max_gap) + 5 * (`INVSQRT_LATENCY + 2);
    localparam int watchdog_cycles = test_cycles + `INVSQRT_LATENCY + 20;
    // 2^-30
    localparam real rel_limit = 1.0 / 1073741824.0;

    // One operand in flight and its send time
    typedef struct packed {
        logic [63:0] operand;
        logic [63:0] sent;
    } entry_t;

    logic            clk;
    logic            reset;
    logic            in_valid;
    fp64_pkg::fp64_t fp_in;
    logic            out_valid;
    fp64_pkg::fp64_t fp_out;

    entry_t      pending [$];
    logic [31:0] lfsr_state;
    int          pass_count = 0;
    int          fail_count = 0;
    int          fail_mark = 0;

    // NaNs, negatives, infinities, zeros and denormals
    logic [63:0] specials [n_special] = '{
        64'h7ff8_0000_0000_0000, 64'h7ff0_0000_0000_0001, 64'hfff8_0000_0000_0000,
        64'hbff0_0000_0000_0000, 64'hfff0_0000_0000_0000, 64'h800f_ffff_ffff_ffff,
        64'h8000_0000_0000_0001, 64'h7ff0_0000_0000_0000, 64'h0000_0000_0000_0000,
        64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001, 64'h000f_ffff_ffff_ffff
    };

    fp64_invsqrt fp64_invsqrt_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .fp_in     (fp_in),
        .out_valid (out_valid),
        .fp_out    (fp_out)
    );

    bind fp64_invsqrt fp64_invsqrt_properties props_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .fp_in     (fp_in),
        .out_valid (out_valid),
        .fp_out    (fp_out)
    );

    always #(period / 2) clk = ~clk;

    // ====================
    // Stimulus helpers
    // ====================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [63:0] power_of_four(input int k);
        return {1'b0, 11'(1023 + 2 * k), 52'd0};
    endfunction

    // Exponent kept inside 1..2046
    task automatic random_normal(output logic [63:0] x);
        logic [63:0] e;
        logic [63:0] f;
        take_bits(11, e);
        take_bits(52, f);
        x = {1'b0, 11'((e % 2046) + 1), f[51:0]};
    endtask

    // Rotates through specials, powers of four and random normals
    task automatic pick_operand(input int sel, output logic [63:0] x);
        logic [63:0] bits;
        case (sel % 3)
            0: begin
                take_bits(4, bits);
                x = specials[bits % n_special];
            end
            1: begin
                take_bits(8, bits);
                x = power_of_four(int'(bits) - 128);
            end
            default: random_normal(x);
        endcase
    endtask

    task automatic send(input logic [63:0] x);
        entry_t ent;
        @(negedge clk);
        in_valid = 1'b1;
        fp_in = x;
        ent.operand = x;
        ent.sent = $time;
        pending.push_back(ent);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // ====================
    // Expected values
    // ====================
    // Returns 1 with the encoding when the class fixes the result
    function automatic bit special_expect(input logic [63:0] x, output logic [63:0] r);
        r = '0;
        if (x[62:52] == 11'h7ff && x[51:0] != '0) begin
            r = `FP64_QNAN;
            return 1'b1;
        end
        // Negative denormals count too, only zero escapes
        if (x[63] && x[62:0] != '0) begin
            r = `FP64_QNAN;
            return 1'b1;
        end
        if (x[62:52] == 11'h7ff) begin
            r = `FP64_POS_ZERO;
            return 1'b1;
        end
        if (x[62:52] == '0) begin
            r = `FP64_POS_INF;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_output();
        entry_t      ent;
        logic [63:0] want;
        bit          exact;
        int          unb;
        real         ref_val;
        real         rel;
        if (pending.size() == 0) begin
            $display("out_valid was high at %0t with no operand in flight", $time);
            fail_count++;
            return;
        end
        ent = pending.pop_front();
        assert ($time == ent.sent + lat_ns) begin
            pass_count++;
        end else begin
            $display("Result for operand %h came %0t ns after it was sent, not %0d ns",
                ent.operand, $time - ent.sent, lat_ns);
            fail_count++;
        end
        exact = special_expect(ent.operand, want);
        unb = int'(ent.operand[62:52]) - 1023;
        // 4^k maps exactly to 2^-k
        if (!exact && ent.operand[51:0] == '0 && unb % 2 == 0) begin
            exact = 1'b1;
            want = {1'b0, 11'(1023 - unb / 2), 52'd0};
        end
        if (exact) begin
            assert (fp_out === want) begin
                pass_count++;
            end else begin
                $display("** Error: fp_out = %h, expected %h for operand %h",
                    fp_out, want, ent.operand);
                fail_count++;
            end
        end else begin
            ref_val = 1.0 / $sqrt($bitstoreal(ent.operand));
            rel = ($bitstoreal(fp_out) - ref_val) / ref_val;
            if (rel < 0.0) begin
                rel = -rel;
            end
            assert (fp_out[63] == 1'b0 && rel < rel_limit) begin
                pass_count++;
            end else begin
                $display("** Error: fp_out = %h, expected about %h for operand %h",
                    fp_out, $realtobits(ref_val), ent.operand);
                fail_count++;
            end
        end
    endtask

    // Scoreboard, outputs are stable on the falling edge
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            check_output();
        end
    end

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (out_valid === 1'b0) begin
                pass_count++;
            end else begin
                $display("out_valid was high at %0t during reset or idle", $time);
                fail_count++;
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        idle(1);
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        $display("test %0d %s done, %0d failures", num, name, fail_count - fail_mark);
        fail_mark = fail_count;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        int          fail_total;
        logic [63:0] x;
        logic [63:0] g;
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        fp_in = '0;
        lfsr_state = 32'hca2f_961e;

        check_idle(reset_cycles);
        reset = 1'b0;
        check_idle(idle_cycles);
        $display("test 1 reset and idle done, %0d failures", fail_count - fail_mark);
        fail_mark = fail_count;

        foreach (specials[i]) begin
            send(specials[i]);
        end
        end_test(2, "special cases");

        for (int k = -200; k <= 200; k += 10) begin
            send(power_of_four(k));
        end
        end_test(3, "powers of four");

        repeat (n_random) begin
            random_normal(x);
            send(x);
        end
        end_test(4, "random accuracy");

        // Back to back, then random gaps of up to max_gap cycles
        for (int i = 0; i < n_burst; i++) begin
            pick_operand(i, x);
            send(x);
        end
        for (int i = 0; i < n_gapped; i++) begin
            take_bits(2, g);
            idle(int'(g));
            pick_operand(i, x);
            send(x);
        end
        end_test(5, "throughput and order");

        fail_total = fail_count + fp64_invsqrt_i.props_i.assert_fails;
        $display("checks passed %0d, failed %0d", pass_count, fail_total);
        if (fail_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_cycles * period);
        $display("Watchdog expired after %0d cycles, the run did not complete",
            watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- fp64_invsqrt.f
+incdir+include
hw/fp64_pkg.sv
hw/invsqrt_pkg.sv
hw/invsqrt_ifs.sv
hw/fp_classify.sv
hw/invsqrt_seed_rom.sv
hw/invsqrt_newton.sv
hw/invsqrt_result_select.sv
hw/fp64_invsqrt.sv
sim/fp64_invsqrt_properties.sv
sim/fp64_invsqrt_tb.sv

//--- Makefile
# Verilator build and run of the reciprocal square root testbench
VERILATOR ?= verilator
TOP       ?= fp64_invsqrt_tb
FILELIST  ?= fp64_invsqrt.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
